// ==== src/cmd_pkg.sv ====
`default_nettype none

package cmd_pkg;

    localparam int OP_W  = 2;
    localparam int ARG_W = 4;

    // argument fields
    localparam int COLOR_ARG_W = 2;    // low bits of arg hold a colour mode
    localparam int ENABLE_BIT  = 0;

    typedef enum logic [OP_W-1:0] {
        OP_SET_GLYPH = 2'd0,    // arg is a glyph code
        OP_SET_COLOR = 2'd1,
        OP_BLANK     = 2'd2,    // glyph back to none
        OP_ENABLE    = 2'd3     // global, panel field ignored
    } opcode_t;

endpackage

`default_nettype wire

// ==== src/glyph_panel.sv ====
`timescale 1ns/1ps
`default_nettype none

module glyph_panel
    import matrix_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 frame_start,
    input  logic [ROW_IDX_W-1:0] row_idx,
    input  glyph_t               shadow_glyph,
    input  color_t               shadow_color,
    output logic [COLS-1:0]      col_red,
    output logic [COLS-1:0]      col_green
);

    glyph_t          disp_glyph;
    color_t          disp_color;
    logic [COLS-1:0] bitmap;

    // bitmap of one glyph row, bit 0 is column 0
    function automatic logic [COLS-1:0] glyph_row(input glyph_t g,
                                                  input logic [ROW_IDX_W-1:0] r);
        logic [COLS-1:0] bits;
        bits = '0;
        case (g)
            LEVEL_0:
                case (r)
                    3'd2, 3'd5: bits = 8'b0001_1000;
                    3'd3, 3'd4: bits = 8'b0011_1100;
                    default:    bits = '0;
                endcase
            LEVEL_1:
                case (r)
                    3'd2, 3'd5: bits = 8'b0011_1000;
                    3'd3, 3'd4: bits = 8'b0111_1100;
                    default:    bits = '0;
                endcase
            LEVEL_2:
                case (r)
                    3'd2, 3'd5: bits = 8'b0011_1100;
                    3'd3, 3'd4: bits = 8'b0111_1110;
                    default:    bits = '0;
                endcase
            LEVEL_3:
                case (r)
                    3'd1, 3'd6:             bits = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5: bits = 8'b0111_1110;
                    default:                bits = '0;
                endcase
            LEVEL_4:
                case (r)
                    3'd0, 3'd7: bits = 8'b0011_1100;
                    3'd1, 3'd6: bits = 8'b0111_1110;
                    default:    bits = 8'b1111_1111;
                endcase
            FULL:
                bits = '1;
            WAVE:
                case (r)
                    3'd0:    bits = 8'b1100_0011;
                    3'd1:    bits = 8'b1110_0011;
                    3'd2:    bits = 8'b1111_0001;
                    3'd3:    bits = 8'b1110_0011;
                    3'd4:    bits = 8'b1100_0111;
                    3'd5:    bits = 8'b1110_0111;
                    3'd6:    bits = 8'b1111_0111;
                    default: bits = 8'b1111_1011;
                endcase
            RISE:
                case (r)
                    3'd1:    bits = 8'b0000_0001;
                    3'd2:    bits = 8'b1000_0001;
                    3'd3:    bits = 8'b1100_0011;
                    3'd4:    bits = 8'b1000_0011;
                    3'd5:    bits = 8'b1100_0111;
                    3'd6:    bits = 8'b1110_0111;
                    3'd7:    bits = 8'b1111_0011;
                    default: bits = '0;
                endcase
            RING:
                case (r)
                    3'd1:    bits = 8'b0011_1000;
                    3'd2:    bits = 8'b0100_0100;
                    3'd3:    bits = 8'b0101_1010;
                    3'd4:    bits = 8'b0100_1010;
                    3'd5:    bits = 8'b0011_0010;
                    3'd6:    bits = 8'b1100_0100;
                    3'd7:    bits = 8'b0011_1000;
                    default: bits = '0;
                endcase
            DROP:
                case (r)
                    3'd2:    bits = 8'b0110_0000;
                    3'd3:    bits = 8'b1111_1100;
                    3'd4:    bits = 8'b0011_1111;
                    3'd5:    bits = 8'b0011_1110;
                    3'd6:    bits = 8'b0001_1100;
                    default: bits = '0;
                endcase
            BELL:
                case (r)
                    3'd2:       bits = 8'b0001_1000;
                    3'd3:       bits = 8'b0011_1100;
                    3'd4, 3'd5: bits = 8'b0111_1110;
                    3'd6:       bits = 8'b0010_0100;
                    default:    bits = '0;
                endcase
            HOOK:
                case (r)
                    3'd0:    bits = 8'b1110_0000;
                    3'd1:    bits = 8'b0110_0000;
                    3'd2:    bits = 8'b1110_0000;
                    3'd3:    bits = 8'b0011_0000;
                    3'd4:    bits = 8'b0011_0001;
                    3'd5:    bits = 8'b0011_0011;
                    3'd6:    bits = 8'b0011_1110;
                    default: bits = 8'b0001_1100;
                endcase
            default:
                bits = '0;    // GLYPH_NONE and unused codes
        endcase
        return bits;
    endfunction

    // shadow state only becomes visible at frame start
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            disp_glyph <= GLYPH_NONE;
            disp_color <= COLOR_GREEN;
        end
        else if (frame_start)
        begin
            disp_glyph <= shadow_glyph;
            disp_color <= shadow_color;
        end
    end

    assign bitmap = glyph_row(disp_glyph, row_idx);

    always_comb
    begin
        col_red   = '0;
        col_green = '0;
        case (disp_color)
            COLOR_GREEN: col_green = bitmap;
            COLOR_RED:   col_red   = bitmap;
            COLOR_AMBER:
            begin
                col_red   = bitmap;
                col_green = bitmap;
            end
            default:     ;    // off
        endcase
    end

endmodule

`default_nettype wire

// ==== src/matrix_display_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module matrix_display_top
    import matrix_pkg::*, cmd_pkg::*;
#(
    parameter int NUM_PANELS  = 4,
    parameter int SCAN_DIV    = 4,
    parameter int PANEL_IDX_W = (NUM_PANELS > 1) ? $clog2(NUM_PANELS) : 1
)
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cmd_valid,
    input  opcode_t                    cmd_op,
    input  logic [PANEL_IDX_W-1:0]     cmd_panel,
    input  logic [ARG_W-1:0]           cmd_arg,
    output logic [ROWS-1:0]            row_n,
    output logic [NUM_PANELS*COLS-1:0] col_red_all,
    output logic [NUM_PANELS*COLS-1:0] col_green_all
);

    logic [ROW_IDX_W-1:0]       row_idx;
    logic                       frame_start;
    logic                       row_start;
    logic                       display_en;
    glyph_t                     shadow_glyph [NUM_PANELS];
    color_t                     shadow_color [NUM_PANELS];
    logic [NUM_PANELS*COLS-1:0] col_red_bus;
    logic [NUM_PANELS*COLS-1:0] col_green_bus;

    panel_control #(
        .NUM_PANELS  (NUM_PANELS),
        .SCAN_DIV    (SCAN_DIV),
        .PANEL_IDX_W (PANEL_IDX_W)
    ) u_control (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_panel    (cmd_panel),
        .cmd_arg      (cmd_arg),
        .row_idx      (row_idx),
        .frame_start  (frame_start),
        .row_start    (row_start),
        .display_en   (display_en),
        .shadow_glyph (shadow_glyph),
        .shadow_color (shadow_color)
    );

    // panel i drives byte i of the column buses
    for (genvar i = 0; i < NUM_PANELS; i++)
    begin : g_panel
        glyph_panel u_panel (
            .clk          (clk),
            .rst          (rst),
            .frame_start  (frame_start),
            .row_idx      (row_idx),
            .shadow_glyph (shadow_glyph[i]),
            .shadow_color (shadow_color[i]),
            .col_red      (col_red_bus[i*COLS +: COLS]),
            .col_green    (col_green_bus[i*COLS +: COLS])
        );
    end

    row_driver #(
        .NUM_PANELS (NUM_PANELS)
    ) u_driver (
        .clk           (clk),
        .rst           (rst),
        .row_idx       (row_idx),
        .row_start     (row_start),
        .display_en    (display_en),
        .col_red_in    (col_red_bus),
        .col_green_in  (col_green_bus),
        .row_n         (row_n),
        .col_red_all   (col_red_all),
        .col_green_all (col_green_all)
    );

endmodule

`default_nettype wire

// ==== src/matrix_pkg.sv ====
`default_nettype none

package matrix_pkg;

    // one panel is 8x8, all panels share the row lines
    localparam int ROWS      = 8;
    localparam int COLS      = 8;
    localparam int ROW_IDX_W = $clog2(ROWS);

    // built-in glyphs, codes 12..14 unused
    typedef enum logic [3:0] {
        LEVEL_0    = 4'd0,
        LEVEL_1    = 4'd1,
        LEVEL_2    = 4'd2,
        LEVEL_3    = 4'd3,
        LEVEL_4    = 4'd4,
        FULL       = 4'd5,
        WAVE       = 4'd6,
        RISE       = 4'd7,
        RING       = 4'd8,
        DROP       = 4'd9,
        BELL       = 4'd10,
        HOOK       = 4'd11,
        GLYPH_NONE = 4'd15
    } glyph_t;

    // which column bus gets the bitmap
    typedef enum logic [1:0] {
        COLOR_GREEN = 2'd0,    // green only
        COLOR_RED   = 2'd1,    // red only
        COLOR_AMBER = 2'd2,    // red and green together
        COLOR_OFF   = 2'd3
    } color_t;

endpackage

`default_nettype wire

// ==== src/panel_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module panel_control
    import matrix_pkg::*, cmd_pkg::*;
#(
    parameter int NUM_PANELS  = 4,
    parameter int SCAN_DIV    = 4,
    parameter int PANEL_IDX_W = 2
)
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cmd_valid,
    input  opcode_t                cmd_op,
    input  logic [PANEL_IDX_W-1:0] cmd_panel,
    input  logic [ARG_W-1:0]       cmd_arg,
    output logic [ROW_IDX_W-1:0]   row_idx,
    output logic                   frame_start,
    output logic                   row_start,
    output logic                   display_en,
    output glyph_t                 shadow_glyph [NUM_PANELS],
    output color_t                 shadow_color [NUM_PANELS]
);

    localparam int DIV_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic             row_end;

    assign row_end = (div_cnt == DIV_W'(SCAN_DIV - 1));

    // prescaler and row counter
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt     <= '0;
            row_idx     <= '0;
            row_start   <= 1'b0;
            frame_start <= 1'b0;
        end
        else
        begin
            row_start   <= row_end;
            frame_start <= row_end && (row_idx == ROW_IDX_W'(ROWS - 1));
            if (row_end)
            begin
                div_cnt <= '0;
                if (row_idx == ROW_IDX_W'(ROWS - 1))
                    row_idx <= '0;
                else
                    row_idx <= row_idx + 1'b1;
            end
            else
            begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // command decode into shadow state
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            display_en <= 1'b1;
            for (int i = 0; i < NUM_PANELS; i++)
            begin
                shadow_glyph[i] <= GLYPH_NONE;
                shadow_color[i] <= COLOR_GREEN;
            end
        end
        else if (cmd_valid)
        begin
            if (cmd_op == OP_ENABLE)
                display_en <= cmd_arg[ENABLE_BIT];
            // indices past the last panel never match
            for (int i = 0; i < NUM_PANELS; i++)
            begin
                if (cmd_panel == PANEL_IDX_W'(i))
                begin
                    case (cmd_op)
                        OP_SET_GLYPH: shadow_glyph[i] <= glyph_t'(cmd_arg);
                        OP_SET_COLOR: shadow_color[i] <= color_t'(cmd_arg[COLOR_ARG_W-1:0]);
                        OP_BLANK:     shadow_glyph[i] <= GLYPH_NONE;
                        default:      ;
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/row_driver.sv ====
`timescale 1ns/1ps
`default_nettype none

module row_driver
    import matrix_pkg::*;
#(
    parameter int NUM_PANELS = 4
)
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic [ROW_IDX_W-1:0]       row_idx,
    input  logic                       row_start,
    input  logic                       display_en,
    input  logic [NUM_PANELS*COLS-1:0] col_red_in,
    input  logic [NUM_PANELS*COLS-1:0] col_green_in,
    output logic [ROWS-1:0]            row_n,
    output logic [NUM_PANELS*COLS-1:0] col_red_all,
    output logic [NUM_PANELS*COLS-1:0] col_green_all
);

    logic [ROWS-1:0] row_dec;

    // one-hot, active low
    assign row_dec = ~(ROWS'(1) << row_idx);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_n         <= '1;
            col_red_all   <= '0;
            col_green_all <= '0;
        end
        else if (!display_en)
        begin
            // scan keeps running, outputs just go dark
            row_n         <= '1;
            col_red_all   <= '0;
            col_green_all <= '0;
        end
        else
        begin
            row_n <= row_dec;
            if (row_start)
            begin
                // blank while the row lines switch over
                col_red_all   <= '0;
                col_green_all <= '0;
            end
            else
            begin
                col_red_all   <= col_red_in;
                col_green_all <= col_green_in;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
src/matrix_pkg.sv
src/cmd_pkg.sv
src/panel_control.sv
src/glyph_panel.sv
src/row_driver.sv
src/matrix_display_top.sv
verification/matrix_display_checker.sv
verification/tb_matrix_display.sv

// ==== verification/matrix_display_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module matrix_display_checker
    import matrix_pkg::*;
#(
    parameter int NUM_PANELS = 4
)
(
    input logic                       clk,
    input logic                       rst,
    input logic                       row_start,
    input logic [ROWS-1:0]            row_n,
    input logic [NUM_PANELS*COLS-1:0] col_red_all,
    input logic [NUM_PANELS*COLS-1:0] col_green_all
);

    int assert_fails = 0;    // failure tally

    // at most one row line low
    row_drive_legal: assert property (@(posedge clk) disable iff (rst)
        (row_n == '1) || $onehot(~row_n))
    else
    begin
        assert_fails++;
        $error("row_n drives more than one row: %b", row_n);
    end

    blank_after_row_start: assert property (@(posedge clk) disable iff (rst)
        row_start |=> (col_red_all == '0 && col_green_all == '0))
    else
    begin
        assert_fails++;
        $error("columns not blank in the first cycle of a row");
    end

    reset_outputs_idle: assert property (@(posedge clk)
        rst |-> (row_n == '1 && col_red_all == '0 && col_green_all == '0))
    else
    begin
        assert_fails++;
        $error("outputs active during reset");
    end

endmodule

bind row_driver matrix_display_checker #(
    .NUM_PANELS (NUM_PANELS)
) u_checker (
    .clk           (clk),
    .rst           (rst),
    .row_start     (row_start),
    .row_n         (row_n),
    .col_red_all   (col_red_all),
    .col_green_all (col_green_all)
);

`default_nettype wire

// ==== verification/matrix_testdata.txt ====
# G code row0 .. row7 : glyph bitmap rows in hex, bit 0 is column 0
# C op panel arg check : op 0 glyph, 1 colour, 2 blank, 3 enable; arg in hex; check 1 compares a frame
G 0 00 00 18 3C 3C 18 00 00
G 1 00 00 38 7C 7C 38 00 00
G 2 00 00 3C 7E 7E 3C 00 00
G 3 00 3C 7E 7E 7E 7E 3C 00
G 4 3C 7E FF FF FF FF 7E 3C
G 5 FF FF FF FF FF FF FF FF
G 6 C3 E3 F1 E3 C7 E7 F7 FB
G 7 00 01 81 C3 83 C7 E7 F3
G 8 00 38 44 5A 4A 32 C4 38
G 9 00 00 60 FC 3F 3E 1C 00
G 10 00 00 18 3C 7E 7E 24 00
G 11 E0 60 E0 30 31 33 3E 1C
# every glyph once, panels in turn
C 0 0 0 1
C 0 1 1 1
C 0 2 2 1
C 0 3 3 1
C 0 0 4 1
C 0 1 5 1
C 0 2 6 1
C 0 3 7 1
C 0 0 8 1
C 0 1 9 1
C 0 2 a 1
C 0 3 b 1
# colour modes, then blank
C 1 0 1 1
C 1 1 2 1
C 1 2 3 1
C 2 3 0 1
# display off and on again
C 3 2 0 1
C 3 0 1 1
# several commands inside one frame
C 0 0 5 0
C 1 0 2 0
C 0 3 6 0
C 1 3 1 1
# second section, panel index past the last panel
C 0 4 0 0
C 1 5 1 0
C 2 7 0 1

// ==== verification/tb_matrix_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_matrix_display
    import matrix_pkg::*, cmd_pkg::*;
();

    localparam int NUM_PANELS   = 4;
    localparam int SCAN_DIV     = 4;
    localparam int PANEL_IDX_W  = 3;    // wide enough to address missing panels
    localparam int FRAME_CYCLES = ROWS * SCAN_DIV;
    localparam int BUS_W        = NUM_PANELS * COLS;

    logic                   clk;
    logic                   rst;
    logic                   cmd_valid;
    opcode_t                cmd_op;
    logic [PANEL_IDX_W-1:0] cmd_panel;
    logic [ARG_W-1:0]       cmd_arg;
    logic [ROWS-1:0]        row_n;
    logic [BUS_W-1:0]       col_red_all;
    logic [BUS_W-1:0]       col_green_all;

    logic [COLS-1:0]      glyph_bits [16][ROWS];
    int                   q_op [$];
    int                   q_panel [$];
    int                   q_arg [$];
    int                   q_chk [$];
    glyph_t               m_glyph [NUM_PANELS];
    color_t               m_color [NUM_PANELS];
    logic                 m_en;
    logic [ROWS*COLS-1:0] cap_red [NUM_PANELS];
    logic [ROWS*COLS-1:0] cap_green [NUM_PANELS];
    int                   row_errs;
    int                   col_errs;
    int                   blank_errs;
    int                   data_errs;
    int                   total;
    bit                   loaded;

    matrix_display_top #(
        .NUM_PANELS  (NUM_PANELS),
        .SCAN_DIV    (SCAN_DIV),
        .PANEL_IDX_W (PANEL_IDX_W)
    ) dut (
        .clk           (clk),
        .rst           (rst),
        .cmd_valid     (cmd_valid),
        .cmd_op        (cmd_op),
        .cmd_panel     (cmd_panel),
        .cmd_arg       (cmd_arg),
        .row_n         (row_n),
        .col_red_all   (col_red_all),
        .col_green_all (col_green_all)
    );

    always #50 clk = ~clk;

    task automatic load_testdata;
        int              fd;
        int              g;
        int              n_glyphs;
        int              op;
        int              panel;
        int              arg;
        int              chk;
        logic [COLS-1:0] b [ROWS];
        string           line;
        n_glyphs = 0;
        fd = $fopen("verification/matrix_testdata.txt", "r");
        if (fd == 0)
        begin
            data_errs++;
            $display("could not open the test data file verification/matrix_testdata.txt");
            return;
        end
        while ($fgets(line, fd) > 0)
        begin
            if (line.substr(0, 0) == "G")
            begin
                if ($sscanf(line, "G %d %h %h %h %h %h %h %h %h", g, b[0], b[1], b[2],
                            b[3], b[4], b[5], b[6], b[7]) == 9 && g < 16)
                begin
                    n_glyphs++;
                    for (int r = 0; r < ROWS; r++)
                        glyph_bits[g][r] = b[r];
                end
            end
            else if (line.substr(0, 0) == "C")
            begin
                if ($sscanf(line, "C %d %d %h %d", op, panel, arg, chk) == 4)
                begin
                    q_op.push_back(op);
                    q_panel.push_back(panel);
                    q_arg.push_back(arg);
                    q_chk.push_back(chk);
                end
            end
        end
        $fclose(fd);
        if (n_glyphs != 12 || q_op.size() == 0)
        begin
            data_errs++;
            $display("test data file holds %0d glyphs and %0d commands, expected 12 glyphs",
                     n_glyphs, q_op.size());
        end
    endtask

    task automatic check_row_drive(input string name, input logic [ROWS-1:0] exp,
                                   input logic [ROWS-1:0] act);
        if (act !== exp)
        begin
            row_errs++;
            $display("MISMATCH %s: row_n expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_blank(input string name, input logic [BUS_W-1:0] red,
                               input logic [BUS_W-1:0] green);
        if (red !== '0 || green !== '0)
        begin
            blank_errs++;
            $display("MISMATCH %s: blank columns expected %h/%h, actual %h/%h",
                     name, BUS_W'(0), BUS_W'(0), red, green);
        end
    endtask

    task automatic check_columns(input string name, input color_t mode, input glyph_t g,
                                 input logic [ROWS*COLS-1:0] red,
                                 input logic [ROWS*COLS-1:0] green);
        logic [ROWS*COLS-1:0] bits;
        logic [ROWS*COLS-1:0] exp_red;
        logic [ROWS*COLS-1:0] exp_green;
        for (int r = 0; r < ROWS; r++)
            bits[r*COLS +: COLS] = (g == GLYPH_NONE) ? '0 : glyph_bits[g][r];
        exp_red   = (mode == COLOR_RED || mode == COLOR_AMBER) ? bits : '0;
        exp_green = (mode == COLOR_GREEN || mode == COLOR_AMBER) ? bits : '0;
        if (red !== exp_red)
        begin
            col_errs++;
            $display("MISMATCH %s: red expected %h, actual %h", name, exp_red, red);
        end
        if (green !== exp_green)
        begin
            col_errs++;
            $display("MISMATCH %s: green expected %h, actual %h", name, exp_green, green);
        end
    endtask

    task automatic send_cmd(input opcode_t op, input int panel, input logic [ARG_W-1:0] arg);
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_panel = PANEL_IDX_W'(panel);
        cmd_arg   = arg;
    endtask

    task automatic release_cmd;
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    // expected panel state after each command
    task automatic apply_model(input opcode_t op, input int panel, input logic [ARG_W-1:0] arg);
        if (op == OP_ENABLE)
            m_en = arg[0];
        else if (panel < NUM_PANELS)
            case (op)
                OP_SET_GLYPH: m_glyph[panel] = glyph_t'(arg);
                OP_SET_COLOR: m_color[panel] = color_t'(arg[1:0]);
                default:      m_glyph[panel] = GLYPH_NONE;
            endcase
    endtask

    // returns in the first output cycle of row 0
    task automatic wait_frame_start;
        logic [ROWS-1:0] prev;
        prev = row_n;
        @(negedge clk);
        while (!(row_n == 8'hfe && prev != 8'hfe))
        begin
            prev = row_n;
            @(negedge clk);
        end
    endtask

    task automatic capture_frame(input string name);
        logic [ROWS-1:0] exp_row;
        for (int r = 0; r < ROWS; r++)
        begin
            exp_row    = '1;
            exp_row[r] = 1'b0;    // only this row line pulled low
            for (int k = 0; k < SCAN_DIV; k++)
            begin
                if (r != 0 || k != 0)
                    @(negedge clk);
                check_row_drive($sformatf("%s row %0d", name, r), exp_row, row_n);
                if (k == 0)
                    check_blank($sformatf("%s row %0d", name, r), col_red_all, col_green_all);
                if (k == SCAN_DIV - 1)
                    for (int p = 0; p < NUM_PANELS; p++)
                    begin
                        cap_red[p][r*COLS +: COLS]   = col_red_all[p*COLS +: COLS];
                        cap_green[p][r*COLS +: COLS] = col_green_all[p*COLS +: COLS];
                    end
            end
        end
    endtask

    task automatic compare_frame(input string name);
        repeat (2) wait_frame_start();
        capture_frame(name);
        for (int p = 0; p < NUM_PANELS; p++)
            check_columns($sformatf("%s panel %0d", name, p), m_color[p], m_glyph[p],
                          cap_red[p], cap_green[p]);
    endtask

    // enable acts at the strobe edge, outputs dark one register stage later
    task automatic expect_dark(input string name);
        repeat (FRAME_CYCLES)
        begin
            @(negedge clk);
            check_row_drive(name, '1, row_n);
            check_blank(name, col_red_all, col_green_all);
        end
    endtask

    initial
    begin
        clk        = 1'b0;
        rst        = 1'b1;
        cmd_valid  = 1'b0;
        cmd_op     = OP_SET_GLYPH;
        cmd_panel  = '0;
        cmd_arg    = '0;
        row_errs   = 0;
        col_errs   = 0;
        blank_errs = 0;
        data_errs  = 0;
        m_en       = 1'b1;
        for (int p = 0; p < NUM_PANELS; p++)
        begin
            m_glyph[p] = GLYPH_NONE;
            m_color[p] = COLOR_GREEN;
        end
        for (int g = 0; g < 16; g++)
            for (int r = 0; r < ROWS; r++)
                glyph_bits[g][r] = '0;
        load_testdata();
        loaded = 1'b1;
        repeat (10) @(negedge clk);
        check_row_drive("in reset", '1, row_n);
        check_blank("in reset", col_red_all, col_green_all);
        rst = 1'b0;
        compare_frame("after reset");
        for (int i = 0; i < q_op.size(); i++)
        begin
            send_cmd(opcode_t'(q_op[i]), q_panel[i], ARG_W'(q_arg[i]));
            apply_model(opcode_t'(q_op[i]), q_panel[i], ARG_W'(q_arg[i]));
            if (q_chk[i] != 0)
            begin
                release_cmd();
                if (m_en)
                    compare_frame($sformatf("cmd %0d", i));
                else
                    expect_dark($sformatf("cmd %0d dark", i));
            end
        end
        release_cmd();
        total = row_errs + col_errs + blank_errs + data_errs
              + dut.u_driver.u_checker.assert_fails;
        $display("errors: row drive %0d, columns %0d, blanking %0d, data %0d, assertions %0d",
                 row_errs, col_errs, blank_errs, data_errs,
                 dut.u_driver.u_checker.assert_fails);
        if (total == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    // each checked command needs at most three frames
    initial
    begin
        wait (loaded);
        repeat ((q_op.size() * 3 + 8) * FRAME_CYCLES) @(posedge clk);
        $display("timeout: the command script did not finish in the expected number of cycles");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
